// ==== src/uncore_pkg.sv ====
// ================================================
// Shared types and address map for the uncore
// Address bits 15:12 select the device and bits 1:0
// the register; the bits in between are ignored
// Device 0 is config, 1 is the CLINT, all others
// go to the loopback
// ================================================

`default_nettype none

package uncore_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  dev_t;
  typedef logic [1:0]  reg_idx_t;

  // Field positions inside addr_t
  localparam int dev_lsb_c = 12;
  localparam int idx_lsb_c = 0;

  localparam dev_t cfg_dev_c   = 4'd0;
  localparam dev_t clint_dev_c = 4'd1;

  typedef enum logic [1:0]
  {
    e_idle,
    e_issue,
    e_wait,
    e_resp
  } dispatch_state_e;

endpackage

`default_nettype wire

// ==== src/mem_dev_if.sv ====
// ================================================
// One command and its response between the
// dispatcher and a device slice
// v is a single-cycle pulse and is always accepted;
// rsp_v follows exactly one cycle later
// ================================================

`timescale 1ns/1ps
`default_nettype none

interface mem_dev_if
  import uncore_pkg::*;
  ();

  logic     v;
  logic     we;
  reg_idx_t idx;
  data_t    wdata;

  logic     rsp_v;
  data_t    rdata;

  modport ctrl
  (
    output v, we, idx, wdata,
    input  rsp_v, rdata
  );

  modport dev
  (
    input  v, we, idx, wdata,
    output rsp_v, rdata
  );

endinterface

`default_nettype wire

// ==== src/fwd_dispatch.sv ====
// ================================================
// Command dispatcher for a single processor port
// Only one command is outstanding at a time, so the
// response path is a single register
// Loopback commands walk the same states with no
// issue, keeping the latency at three cycles
// ================================================

`timescale 1ns/1ps
`default_nettype none

module fwd_dispatch
  import uncore_pkg::*;
  (
    input  logic  clk_i,
    input  logic  rst_i,

    input  logic  cmd_v_i,
    output logic  cmd_ready_o,
    input  logic  cmd_we_i,
    input  addr_t cmd_addr_i,
    input  data_t cmd_wdata_i,

    output logic  rsp_v_o,
    input  logic  rsp_ready_i,
    output data_t rsp_rdata_o,

    mem_dev_if.ctrl cfg_dev,
    mem_dev_if.ctrl clint_dev
  );

  dispatch_state_e state_r, state_n;

  logic     sel_cfg_r;
  logic     sel_clint_r;
  logic     we_r;
  reg_idx_t idx_r;
  data_t    wdata_r;
  data_t    rdata_r;

  logic  cmd_fire;
  logic  sel_loop;
  logic  sel_rsp_v;
  data_t sel_rdata;
  dev_t  cmd_dev;

  assign cmd_dev  = cmd_addr_i[dev_lsb_c +: $bits(dev_t)];
  assign cmd_fire = cmd_v_i & cmd_ready_o;
  assign sel_loop = ~sel_cfg_r & ~sel_clint_r;

  assign sel_rsp_v = (sel_cfg_r & cfg_dev.rsp_v) | (sel_clint_r & clint_dev.rsp_v);
  assign sel_rdata = sel_clint_r ? clint_dev.rdata : cfg_dev.rdata;

  always_comb
    begin
      state_n = state_r;
      unique case (state_r)
        e_idle:  if (cmd_v_i) state_n = e_issue;
        e_issue: state_n = e_wait;
        // Loopback has no slice to hear from
        e_wait:  if (sel_loop || sel_rsp_v) state_n = e_resp;
        e_resp:  if (rsp_ready_i) state_n = e_idle;
        default: state_n = e_idle;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          state_r     <= e_idle;
          sel_cfg_r   <= 1'b0;
          sel_clint_r <= 1'b0;
        end
      else
        begin
          state_r <= state_n;
          if (cmd_fire)
            begin
              sel_cfg_r   <= (cmd_dev == cfg_dev_c);
              sel_clint_r <= (cmd_dev == clint_dev_c);
            end
        end
    end

  // Command payload and response data
  always_ff @(posedge clk_i)
    begin
      if (cmd_fire)
        begin
          we_r    <= cmd_we_i;
          idx_r   <= cmd_addr_i[idx_lsb_c +: $bits(reg_idx_t)];
          wdata_r <= cmd_wdata_i;
        end
      if (state_r == e_wait)
        rdata_r <= sel_loop ? '0 : sel_rdata;
    end

  assign cfg_dev.v     = (state_r == e_issue) & sel_cfg_r;
  assign cfg_dev.we    = we_r;
  assign cfg_dev.idx   = idx_r;
  assign cfg_dev.wdata = wdata_r;

  assign clint_dev.v     = (state_r == e_issue) & sel_clint_r;
  assign clint_dev.we    = we_r;
  assign clint_dev.idx   = idx_r;
  assign clint_dev.wdata = wdata_r;

  assign cmd_ready_o = (state_r == e_idle);
  assign rsp_v_o     = (state_r == e_resp);
  assign rsp_rdata_o = rdata_r;

endmodule

`default_nettype wire

// ==== src/cfg_slice.sv ====
// ================================================
// Configuration register slice
// Index 0 is the read-only core id; writes to it
// are dropped. Indexes 1 to 3 are scratch words
// Write responses carry zero data
// ================================================

`timescale 1ns/1ps
`default_nettype none

module cfg_slice
  import uncore_pkg::*;
  #(
    parameter data_t core_id_p = '0
  )
  (
    input  logic   clk_i,
    input  logic   rst_i,
    mem_dev_if.dev bus
  );

  data_t scratch_r [1:3];
  data_t rd_val;
  logic  rsp_v_r;
  data_t rdata_r;

  always_comb
    begin
      unique case (bus.idx)
        2'd1:    rd_val = scratch_r[1];
        2'd2:    rd_val = scratch_r[2];
        2'd3:    rd_val = scratch_r[3];
        default: rd_val = core_id_p;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          for (int i = 1; i <= 3; i++)
            scratch_r[i] <= '0;
          rsp_v_r <= 1'b0;
        end
      else
        begin
          rsp_v_r <= bus.v;
          if (bus.v && bus.we && (bus.idx != 2'd0))
            scratch_r[bus.idx] <= bus.wdata;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (bus.v)
        rdata_r <= bus.we ? '0 : rd_val;
    end

  assign bus.rsp_v = rsp_v_r;
  assign bus.rdata = rdata_r;

endmodule

`default_nettype wire

// ==== src/clint_slice.sv ====
// ================================================
// Core-local interruptor slice
// Counter advances once every tick_div_p clocks,
// tick_div_p must be at least 1
// Index 0 is the counter, 1 the compare value,
// 2 and 3 read zero. The timer irq is registered
// ================================================

`timescale 1ns/1ps
`default_nettype none

module clint_slice
  import uncore_pkg::*;
  #(
    parameter int unsigned tick_div_p = 4
  )
  (
    input  logic   clk_i,
    input  logic   rst_i,
    mem_dev_if.dev bus,
    output logic   timer_irq_o
  );

  localparam int div_w_lp = (tick_div_p > 1) ? $clog2(tick_div_p) : 1;

  logic [div_w_lp-1:0] div_cnt_r;
  logic                tick;

  data_t mtime_r;
  data_t mtimecmp_r;
  data_t rd_val;
  logic  rsp_v_r;
  data_t rdata_r;
  logic  irq_r;

  assign tick = (div_cnt_r == div_w_lp'(tick_div_p - 1));

  always_comb
    begin
      unique case (bus.idx)
        2'd0:    rd_val = mtime_r;
        2'd1:    rd_val = mtimecmp_r;
        default: rd_val = '0;
      endcase
    end

  always_ff @(posedge clk_i)
    begin
      if (rst_i)
        begin
          div_cnt_r  <= '0;
          mtime_r    <= '0;
          mtimecmp_r <= '1;
          rsp_v_r    <= 1'b0;
          irq_r      <= 1'b0;
        end
      else
        begin
          div_cnt_r <= tick ? '0 : div_cnt_r + 1'b1;
          // A write to the counter wins over a tick
          if (bus.v && bus.we && (bus.idx == 2'd0))
            mtime_r <= bus.wdata;
          else if (tick)
            mtime_r <= mtime_r + 1'b1;
          if (bus.v && bus.we && (bus.idx == 2'd1))
            mtimecmp_r <= bus.wdata;
          rsp_v_r <= bus.v;
          irq_r   <= (mtime_r >= mtimecmp_r);
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (bus.v)
        rdata_r <= bus.we ? '0 : rd_val;
    end

  assign bus.rsp_v   = rsp_v_r;
  assign bus.rdata   = rdata_r;
  assign timer_irq_o = irq_r;

endmodule

`default_nettype wire

// ==== src/uncore_top.sv ====
// ================================================
// Uncore top level for one processor port
// Valid/ready on both command and response sides;
// a new command is taken only after the previous
// response has been accepted
// ================================================

`timescale 1ns/1ps
`default_nettype none

module uncore_top
  import uncore_pkg::*;
  #(
    parameter data_t       core_id_p  = '0,
    parameter int unsigned tick_div_p = 4
  )
  (
    input  logic  clk_i,
    input  logic  rst_i,

    input  logic  cmd_v_i,
    output logic  cmd_ready_o,
    input  logic  cmd_we_i,
    input  addr_t cmd_addr_i,
    input  data_t cmd_wdata_i,

    output logic  rsp_v_o,
    input  logic  rsp_ready_i,
    output data_t rsp_rdata_o,

    output logic  timer_irq_o
  );

  mem_dev_if cfg_bus ();
  mem_dev_if clint_bus ();

  fwd_dispatch dispatch_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_o (cmd_ready_o),
    .cmd_we_i    (cmd_we_i),
    .cmd_addr_i  (cmd_addr_i),
    .cmd_wdata_i (cmd_wdata_i),
    .rsp_v_o     (rsp_v_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .cfg_dev     (cfg_bus),
    .clint_dev   (clint_bus)
  );

  cfg_slice #(.core_id_p(core_id_p)) cfg_i
  (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (cfg_bus)
  );

  clint_slice #(.tick_div_p(tick_div_p)) clint_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .bus         (clint_bus),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

// ==== tests/uncore_sva.sv ====
// ================================================
// Handshake assertions for uncore_top, bound from
// the testbench. Assumes one command in flight
// ================================================

`timescale 1ns/1ps
`default_nettype none

module uncore_sva
  import uncore_pkg::*;
  (
    input logic  clk_i,
    input logic  rst_i,
    input logic  cmd_v_i,
    input logic  cmd_ready_i,
    input logic  rsp_v_i,
    input logic  rsp_ready_i,
    input data_t rsp_rdata_i
  );

  logic cmd_fire;
  logic rsp_fire;

  assign cmd_fire = cmd_v_i & cmd_ready_i;
  assign rsp_fire = rsp_v_i & rsp_ready_i;

  rsp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_v_i && !rsp_ready_i |=> rsp_v_i && $stable(rsp_rdata_i))
    else $error("Response changed while stalled");

  busy_start_a: assert property (@(posedge clk_i) disable iff (rst_i)
    cmd_fire |=> !cmd_ready_i)
    else $error("Command accepted while one is in flight");

  busy_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    !cmd_ready_i && !rsp_fire |=> !cmd_ready_i)
    else $error("Ready returned before the response transferred");

  // Response rises three cycles after the command, never otherwise
  latency_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(rsp_v_i) == $past(cmd_fire, 3))
    else $error("Response latency is not three cycles");

  reset_a: assert property (@(posedge clk_i)
    $fell(rst_i) |-> cmd_ready_i && !rsp_v_i)
    else $error("Wrong handshake state after reset");

endmodule

`default_nettype wire

// ==== tests/uncore_checker.sv ====
// ================================================
// Response checker for the uncore testbench
// Models the config and CLINT registers and answers
// each command in issue order. Counter reads are
// only bounded from below, never matched exactly
// ================================================

`timescale 1ns/1ps
`default_nettype none

module uncore_checker
  import uncore_pkg::*;
  #(
    parameter data_t core_id_p = '0
  )
  (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       cmd_v_i,
    input  logic       cmd_ready_i,
    input  logic       cmd_we_i,
    input  addr_t      cmd_addr_i,
    input  data_t      cmd_wdata_i,
    input  logic [1:0] kind_i,
    input  data_t      exp_i,
    input  logic       rsp_v_i,
    input  logic       rsp_ready_i,
    input  data_t      rsp_rdata_i,
    input  logic       timer_irq_i,
    output int         err_cnt_o
  );

  data_t scratch [0:3];
  data_t cmp_val;
  data_t cnt_floor;
  logic  cnt_strict;
  logic  irq_due;
  logic  irq_exp;
  int    err_cnt = 0;

  // Bit 2 of the kind entry marks a counter read
  data_t      model_q [$];
  logic [2:0] kind_q [$];
  data_t      exp_q [$];

  assign err_cnt_o = err_cnt;

  task automatic report_value(input string name, input data_t got, input data_t exp);
    $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic take_command();
    dev_t     dev;
    reg_idx_t idx;
    data_t    val;
    logic     ctr;
    dev = cmd_addr_i[15:12];
    idx = cmd_addr_i[1:0];
    val = '0;
    ctr = 1'b0;
    if (cmd_we_i)
      begin
        if (dev == cfg_dev_c && idx != 2'd0)
          scratch[idx] = cmd_wdata_i;
        else if (dev == clint_dev_c && idx == 2'd0)
          begin
            cnt_floor  = cmd_wdata_i;
            cnt_strict = 1'b0;
          end
        else if (dev == clint_dev_c && idx == 2'd1)
          cmp_val = cmd_wdata_i;
      end
    else if (dev == cfg_dev_c)
      val = (idx == 2'd0) ? core_id_p : scratch[idx];
    else if (dev == clint_dev_c)
      begin
        ctr = (idx == 2'd0);
        if (idx == 2'd1)
          val = cmp_val;
      end
    model_q.push_back(val);
    kind_q.push_back({ctr, kind_i});
    exp_q.push_back(exp_i);
  endtask

  task automatic check_response();
    data_t      val;
    logic [2:0] kind;
    data_t      exp;
    if (model_q.size() == 0)
      begin
        $display("Response at %0t arrived with no command outstanding", $time);
        err_cnt++;
        return;
      end
    val  = model_q.pop_front();
    kind = kind_q.pop_front();
    exp  = exp_q.pop_front();
    if (kind[2])
      begin
        if (kind[1:0] == 2'd2 &&
            (cnt_strict ? (rsp_rdata_i <= cnt_floor) : (rsp_rdata_i < cnt_floor)))
          begin
            $display("FAIL t=%0t rsp_rdata_o got %h expected above %h",
                     $time, rsp_rdata_i, cnt_floor);
            err_cnt++;
          end
        cnt_floor  = rsp_rdata_i;
        cnt_strict = 1'b1;
      end
    else if (rsp_rdata_i != val)
      report_value("rsp_rdata_o", rsp_rdata_i, val);
    if (kind[1:0] == 2'd1 && rsp_rdata_i != exp)
      report_value("rsp_rdata_o", rsp_rdata_i, exp);
    if (kind[1:0] == 2'd3)
      begin
        irq_due = 1'b1;
        irq_exp = exp[0];
      end
  endtask

  always @(posedge clk_i)
    begin
      if (rst_i)
        begin
          for (int i = 0; i < 4; i++)
            scratch[i] = '0;
          cmp_val    = '1;
          cnt_floor  = '0;
          cnt_strict = 1'b0;
          irq_due    = 1'b0;
          irq_exp    = 1'b0;
          model_q.delete();
          kind_q.delete();
          exp_q.delete();
        end
      else
        begin
          // One cycle after a response that asked for it
          if (irq_due)
            begin
              irq_due = 1'b0;
              if (timer_irq_i != irq_exp)
                report_value("timer_irq_o", data_t'(timer_irq_i), data_t'(irq_exp));
            end
          if (rsp_v_i && rsp_ready_i)
            check_response();
          if (cmd_v_i && cmd_ready_i)
            take_command();
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_uncore.sv ====
// ================================================
// Testbench for uncore_top
// Commands come from tests/uncore_testdata.txt, read
// relative to the project root, at most 64 of them
// Idle gaps and response stalls are random
// ================================================

`timescale 1ns/1ps
`default_nettype none

module tb_uncore
  import uncore_pkg::*;
  ();

  localparam int    max_cmds_lp = 64;
  localparam data_t core_id_lp  = 32'h0000_00A5;

  logic       clk;
  logic       rst;
  logic       cmd_v;
  logic       cmd_ready;
  logic       cmd_we;
  addr_t      cmd_addr;
  data_t      cmd_wdata;
  logic       rsp_v;
  logic       rsp_ready;
  data_t      rsp_rdata;
  logic       timer_irq;
  logic [1:0] chk_kind;
  data_t      chk_exp;
  int         err_cnt;
  int         tb_errs = 0;
  int         n_cmds = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 0;

  // Five words per command, in data file column order
  logic [31:0] tdata [0:5*max_cmds_lp-1];

  uncore_top #(.core_id_p(core_id_lp), .tick_div_p(4)) uncore_top_i
  (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_v_i     (cmd_v),
    .cmd_ready_o (cmd_ready),
    .cmd_we_i    (cmd_we),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .rsp_v_o     (rsp_v),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .timer_irq_o (timer_irq)
  );

  uncore_checker #(.core_id_p(core_id_lp)) checker_i
  (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_v_i     (cmd_v),
    .cmd_ready_i (cmd_ready),
    .cmd_we_i    (cmd_we),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .kind_i      (chk_kind),
    .exp_i       (chk_exp),
    .rsp_v_i     (rsp_v),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_i (rsp_rdata),
    .timer_irq_i (timer_irq),
    .err_cnt_o   (err_cnt)
  );

  bind uncore_top uncore_sva sva_i
  (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_v_i     (cmd_v_i),
    .cmd_ready_i (cmd_ready_o),
    .rsp_v_i     (rsp_v_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o)
  );

  initial
    begin
      clk = 1'b0;
      forever #20 clk = ~clk;
    end

  always @(posedge clk)
    begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
          $display("Timeout: run did not finish within %0d cycles", cycle_limit);
          $display("Commands %0d, checker errors %0d, testbench errors %0d",
                   n_cmds, err_cnt, tb_errs + 1);
          $display("Finished with errors");
          $finish;
        end
    end

  task automatic run_command(input int idx);
    int stall;
    stall     = $urandom_range(5);
    cmd_we    = tdata[5*idx][0];
    cmd_addr  = tdata[5*idx+1][15:0];
    cmd_wdata = tdata[5*idx+2];
    chk_kind  = tdata[5*idx+3][1:0];
    chk_exp   = tdata[5*idx+4];
    cmd_v     = 1'b1;
    rsp_ready = (stall == 0);
    while (!cmd_ready)
      @(negedge clk);
    @(negedge clk);
    cmd_v = 1'b0;
    while (!rsp_v)
      @(negedge clk);
    repeat (stall)
      @(negedge clk);
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
  endtask

  initial
    begin
      void'($urandom(64358));
      rst       = 1'b1;
      cmd_v     = 1'b0;
      cmd_we    = 1'b0;
      cmd_addr  = '0;
      cmd_wdata = '0;
      rsp_ready = 1'b0;
      chk_kind  = '0;
      chk_exp   = '0;
      for (int i = 0; i < 5*max_cmds_lp; i++)
        tdata[i] = '1;
      $readmemh("tests/uncore_testdata.txt", tdata);
      while (n_cmds < max_cmds_lp && tdata[5*n_cmds] != '1)
        n_cmds++;
      if (n_cmds == 0)
        begin
          $display("No commands found in the data file");
          tb_errs++;
        end
      cycle_limit = n_cmds * 20 + 50;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < n_cmds; i++)
        begin
          repeat ($urandom_range(3)) @(negedge clk);
          run_command(i);
        end
      // Let a pending irq check complete
      repeat (3) @(negedge clk);
      $display("Commands %0d, checker errors %0d, testbench errors %0d",
               n_cmds, err_cnt, tb_errs);
      if (err_cnt == 0 && tb_errs == 0)
        $display("Finished with no errors");
      else
        $display("Finished with errors");
      $finish;
    end

endmodule

`default_nettype wire

// ==== tests/uncore_testdata.txt ====
// Columns: we, addr, wdata, check kind, expected value (hex)
// Kind 0 none, 1 exact, 2 counter above last value, 3 timer irq level after response
0 0000 00000000 1 000000A5
0 0001 00000000 1 00000000
0 0003 00000000 1 00000000
1 0000 DEADBEEF 0 00000000
0 0000 00000000 1 000000A5
1 0001 11111111 1 00000000
1 0FF2 22222222 1 00000000
1 0003 33333333 0 00000000
0 0002 00000000 1 22222222
0 0003 00000000 1 33333333
0 2000 00000000 1 00000000
1 2001 CAFEF00D 1 00000000
1 F001 0BADF00D 0 00000000
0 0001 00000000 1 11111111
0 1001 00000000 1 FFFFFFFF
0 1002 00000000 1 00000000
0 1000 00000000 2 00000000
0 1000 00000000 2 00000000
1 1000 00001000 0 00000000
0 1000 00000000 2 00000000
0 1000 00000000 2 00000000
1 1000 00000000 0 00000000
1 1001 0FFFFFFF 3 00000000
0 1001 00000000 1 0FFFFFFF
1 1001 00000000 3 00000001
1 1001 FFFFFFFF 3 00000000
0 1001 00000000 1 FFFFFFFF

// ==== project.f ====
src/uncore_pkg.sv
src/mem_dev_if.sv
src/fwd_dispatch.sv
src/cfg_slice.sv
src/clint_slice.sv
src/uncore_top.sv
tests/uncore_sva.sv
tests/uncore_checker.sv
tests/tb_uncore.sv

// ==== run_sim.sh ====
#!/bin/sh
# Run from the project root
verilator --binary --timing --assert --top-module tb_uncore -f project.f -o sim_uncore || exit 1
out=$(./obj_dir/sim_uncore)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }
